//--- gat_slice.f
+incdir+include
rtl/gat_pkg.sv
rtl/edge_dispatch.sv
rtl/spmm_unit.sv
rtl/dmvm_unit.sv
rtl/row_aggregator.sv
rtl/pipe_debugger.sv
rtl/gat_slice.sv
verification/gat_slice_tb.sv

//--- Makefile
# Verilator build and run for the gat_slice testbench.

VERILATOR ?= verilator
TOP       ?= gat_slice_tb
RTL_TOP   ?= gat_slice
FILELIST  ?= gat_slice.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/gat_slice_tb.sv
`default_nettype none

`include "gat_defs.svh"

module gat_slice_tb
  import gat_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD    = 4;
  localparam int RESET_CYCLES  = 16;
  localparam int STREAM_GROUPS = 12;
  localparam int BP_GROUPS     = 10;
  localparam int MAX_GROUP     = 4;
  localparam int DBG_GROUP     = 5;
  localparam int DRAIN_LIMIT   = 400;
  // edges of the directed groups plus the worst case of the random ones.
  localparam int MAX_EDGES       = 3 + 11 + (STREAM_GROUPS + BP_GROUPS) * MAX_GROUP;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + 16 * MAX_EDGES + 1000;
  localparam longint LANE_MAX    = (64'd1 << `GAT_OUT_W) - 1;

  logic       clk;
  logic       rst_n;
  logic       in_valid_i;
  edge_rec_t  in_rec_i;
  logic       in_ready_o;
  feat_vec_t  wgt_i;
  logic       out_valid_o;
  out_rec_t   out_rec_o;
  logic       out_ready_i;
  cnt_t       dbg_group_i;
  dbg_flags_t dbg_flags_o;
  cnt_t       dbg_groups_o;
  acc_t       dbg_score_o;

  edge_rec_t   grp_q [$];  // edges of the group being sent.
  out_rec_t    exp_q [$];
  acc_t        score_hist [$];
  acc_t        out_score_q [$];  // scores taken from the output, in order.
  int          err_cnt   = 0;
  int          chk_cnt   = 0;
  int          out_cnt   = 0;
  int          cycle_cnt = 0;
  logic        bp_en     = 1'b0;
  logic        held_valid = 1'b0;
  out_rec_t    held_rec;
  out_rec_t    exp_rec;

  gat_slice gat_slice_i (
    .clk, .rst_n,
    .in_valid_i, .in_rec_i, .in_ready_o,
    .wgt_i,
    .out_valid_o, .out_rec_o, .out_ready_i,
    .dbg_group_i, .dbg_flags_o, .dbg_groups_o, .dbg_score_o
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cycle_cnt++;

  always @(negedge clk) begin
    if (bp_en) out_ready_i = ($urandom % 2) == 0;
    else       out_ready_i = 1'b1;
  end

  //////////////////////////////
  // checking and reference model
  //////////////////////////////

  task automatic check_val(input string name, input logic [127:0] got,
                           input logic [127:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      $display("FAILED at %0d ns: %s got %0h expected %0h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  function automatic longint mul(input feat_t a, input feat_t b);
    return longint'(a) * longint'(b);
  endfunction

  // expected output record of the group held in grp_q.
  function automatic out_rec_t model_rec();
    out_rec_t r;
    longint   sum;
    longint   dot;
    longint   best;
    r = '0;
    for (int l = 0; l < `GAT_LANES; l++) begin
      sum = 0;
      foreach (grp_q[e]) sum += mul(grp_q[e].coef, grp_q[e].feat[l]);
      if (sum < 0)             r.lane[l] = '0;
      else if (sum > LANE_MAX) r.lane[l] = '1;
      else                     r.lane[l] = out_lane_t'(sum);
    end
    best = 0;
    foreach (grp_q[e]) begin
      dot = 0;
      for (int l = 0; l < `GAT_LANES; l++) dot += mul(grp_q[e].feat[l], wgt_i[l]);
      if (e == 0 || dot > best) best = dot;  // the first edge loads the maximum.
    end
    r.score    = acc_t'(best);
    r.edge_cnt = cnt_t'(grp_q.size());
    return r;
  endfunction

  // outputs are sampled a nanosecond after the falling edge, between drive and capture.
  always @(negedge clk) begin
    #1;
    if (rst_n && out_valid_o) begin
      if (held_valid) check_val("out_rec_o while stalled", out_rec_o, held_rec);
      if (out_ready_i) begin
        out_cnt++;
        held_valid = 1'b0;
        out_score_q.push_back(out_rec_o.score);
        if (exp_q.size() == 0) begin
          $display("unexpected output record at %0d ns with no group pending", $time);
          err_cnt++;
        end else begin
          exp_rec = exp_q.pop_front();
          check_val("out_rec_o.lane", out_rec_o.lane, exp_rec.lane);
          check_val("out_rec_o.score", out_rec_o.score, exp_rec.score);
          check_val("out_rec_o.edge_cnt", out_rec_o.edge_cnt, exp_rec.edge_cnt);
        end
      end else begin
        held_valid = 1'b1;
        held_rec   = out_rec_o;
      end
    end else if (held_valid) begin
      $display("out_valid_o dropped at %0d ns before its record was taken", $time);
      err_cnt++;
      held_valid = 1'b0;
    end
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  function automatic edge_rec_t make_edge(input feat_t coef, input feat_t f0, input feat_t f1,
                                          input feat_t f2, input feat_t f3, input logic last);
    edge_rec_t r;
    feat_t     f [4];
    f[0] = f0;
    f[1] = f1;
    f[2] = f2;
    f[3] = f3;
    r.coef = coef;
    for (int l = 0; l < `GAT_LANES; l++) r.feat[l] = f[l % 4];
    r.last = last;
    return r;
  endfunction

  function automatic edge_rec_t random_edge(input logic last);
    edge_rec_t r;
    r.coef = feat_t'($urandom);
    for (int l = 0; l < `GAT_LANES; l++) r.feat[l] = feat_t'($urandom);
    r.last = last;
    return r;
  endfunction

  // called on a falling edge, returns on the falling edge after the transfer.
  task automatic send_rec(input edge_rec_t rec);
    logic taken;
    grp_q.push_back(rec);
    in_valid_i = 1'b1;
    in_rec_i   = rec;
    taken      = 1'b0;
    while (!taken) begin
      #1;
      taken = in_ready_o;
      @(negedge clk);
    end
    in_valid_i = 1'b0;
    if (rec.last) begin
      exp_q.push_back(model_rec());
      score_hist.push_back(exp_q[$].score);
      grp_q.delete();
    end
  endtask

  task automatic send_random_group(input int n);
    for (int e = 0; e < n; e++) send_rec(random_edge(e == n - 1));
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout: %0d output records never arrived", exp_q.size());
      err_cnt++;
    end
    repeat (2) @(negedge clk);
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("test %s: %s", name, (err_cnt == errs_before) ? "ok" : "with errors");
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic test_single_group();
    int errs;
    int start;
    int n;
    errs = err_cnt;
    // no clock edge has passed since reset was released.
    check_val("in_ready_o after reset", in_ready_o, 1'b1);
    check_val("out_valid_o after reset", out_valid_o, 1'b0);
    check_val("dbg_flags_o after reset", dbg_flags_o, '0);
    check_val("dbg_groups_o after reset", dbg_groups_o, '0);
    check_val("dbg_score_o after reset", dbg_score_o, '0);
    send_rec(make_edge(3, 10, -20, 30, -4, 1'b0));
    send_rec(make_edge(-2, 50, 7, -9, 100, 1'b0));
    send_rec(make_edge(5, -1, 40, 12, 0, 1'b1));
    start = cycle_cnt;
    n     = 0;
    #1;
    while (!out_valid_o && n < 20) begin
      @(negedge clk);
      #1;
      n++;
    end
    check_val("out_valid_o latency", cycle_cnt - start, 3);
    @(negedge clk);
    wait_drain();
    report_test("single_group", errs);
  endtask

  task automatic test_clip_relu();
    int errs;
    errs = err_cnt;
    for (int l = 0; l < `GAT_LANES; l++) wgt_i[l] = '0;
    wgt_i[0] = 1;
    wgt_i[1] = -1;  // every dot product of the first group is negative.
    for (int e = 0; e < 5; e++) send_rec(make_edge(-128, -128, 127, 3, 0, e == 4));
    for (int e = 0; e < 6; e++) send_rec(make_edge(100, feat_t'(100 + e), -120, 50, -5, e == 5));
    wait_drain();
    // each edge of the first group scores -128 - 127.
    check_val("negative score kept signed", out_score_q[1], acc_t'(-255));
    report_test("clip_relu", errs);
  endtask

  task automatic test_stream();
    int errs;
    errs = err_cnt;
    for (int l = 0; l < `GAT_LANES; l++) wgt_i[l] = feat_t'($urandom);
    for (int g = 0; g < STREAM_GROUPS; g++) begin
      send_random_group((g % 3 == 0) ? 1 : 1 + int'($urandom % MAX_GROUP));
    end
    wait_drain();
    report_test("stream", errs);
  endtask

  task automatic test_backpressure();
    int errs;
    errs  = err_cnt;
    bp_en = 1'b1;
    for (int g = 0; g < BP_GROUPS; g++) send_random_group(1 + int'($urandom % MAX_GROUP));
    wait_drain();
    bp_en = 1'b0;
    repeat (2) @(negedge clk);
    check_val("output record count", out_cnt, score_hist.size());
    report_test("backpressure", errs);
  endtask

  task automatic test_debugger();
    int errs;
    errs = err_cnt;
    check_val("dbg_flags_o", dbg_flags_o, 8'hff);
    check_val("dbg_groups_o", dbg_groups_o, score_hist.size());
    check_val("dbg_score_o", dbg_score_o, score_hist[DBG_GROUP]);
    report_test("debugger", errs);
  endtask

  initial begin
    void'($urandom(4));
    rst_n       = 1'b0;
    in_valid_i  = 1'b0;
    in_rec_i    = '0;
    wgt_i       = '0;
    out_ready_i = 1'b1;
    dbg_group_i = cnt_t'(DBG_GROUP);
    wgt_i[0]    = 2;
    wgt_i[1]    = -1;
    wgt_i[2]    = 3;
    wgt_i[3]    = 1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_single_group();
    test_clip_relu();
    test_stream();
    test_backpressure();
    test_debugger();
    $display("done: %0d groups, %0d checks, %0d errors", score_hist.size(), chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/gat_slice.sv
`default_nettype none

module gat_slice
  import gat_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire logic      in_valid_i,
  input  wire edge_rec_t in_rec_i,
  output logic           in_ready_o,
  input  wire feat_vec_t wgt_i,
  output logic           out_valid_o,
  output out_rec_t       out_rec_o,
  input  wire logic      out_ready_i,
  input  wire cnt_t      dbg_group_i,
  output dbg_flags_t     dbg_flags_o,
  output cnt_t           dbg_groups_o,
  output acc_t           dbg_score_o
);

  logic      a_valid;
  edge_rec_t a_rec;
  logic      a_ready;
  logic      b_valid;
  edge_rec_t b_rec;
  logic      b_ready;
  logic      spmm_valid;
  spmm_res_t spmm_res;
  logic      spmm_ready;
  logic      score_valid;
  acc_t      score;
  logic      score_ready;

  edge_dispatch edge_dispatch_i (
    .clk, .rst_n,
    .in_valid_i, .in_rec_i, .in_ready_o,
    .a_valid_o (a_valid), .a_rec_o (a_rec), .a_ready_i (a_ready),
    .b_valid_o (b_valid), .b_rec_o (b_rec), .b_ready_i (b_ready)
  );

  // the two units run side by side on the same edge stream.
  spmm_unit spmm_unit_i (
    .clk, .rst_n,
    .edge_valid_i (a_valid), .edge_rec_i (a_rec), .edge_ready_o (a_ready),
    .res_valid_o (spmm_valid), .res_o (spmm_res), .res_ready_i (spmm_ready)
  );

  dmvm_unit dmvm_unit_i (
    .clk, .rst_n,
    .edge_valid_i (b_valid), .edge_rec_i (b_rec), .edge_ready_o (b_ready),
    .wgt_i,
    .score_valid_o (score_valid), .score_o (score), .score_ready_i (score_ready)
  );

  row_aggregator row_aggregator_i (
    .clk, .rst_n,
    .spmm_valid_i (spmm_valid), .spmm_res_i (spmm_res), .spmm_ready_o (spmm_ready),
    .score_valid_i (score_valid), .score_i (score), .score_ready_o (score_ready),
    .out_valid_o, .out_rec_o, .out_ready_i
  );

  pipe_debugger pipe_debugger_i (
    .clk, .rst_n,
    .in_valid_i, .in_ready_i (in_ready_o),
    .a_valid_i (a_valid), .a_ready_i (a_ready),
    .b_valid_i (b_valid), .b_ready_i (b_ready),
    .out_valid_i (out_valid_o), .out_ready_i,
    .out_score_i (out_rec_o.score),
    .dbg_group_i, .dbg_flags_o, .dbg_groups_o, .dbg_score_o
  );

endmodule

`default_nettype wire

//--- rtl/pipe_debugger.sv
`default_nettype none

module pipe_debugger
  import gat_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic in_valid_i,
  input  wire logic in_ready_i,
  input  wire logic a_valid_i,
  input  wire logic a_ready_i,
  input  wire logic b_valid_i,
  input  wire logic b_ready_i,
  input  wire logic out_valid_i,
  input  wire logic out_ready_i,
  input  wire acc_t out_score_i,
  input  wire cnt_t dbg_group_i,
  output dbg_flags_t dbg_flags_o,
  output cnt_t       dbg_groups_o,
  output acc_t       dbg_score_o
);

  dbg_flags_t seen_now;
  dbg_flags_t seen_q;
  cnt_t       groups_q;
  acc_t       score_q;
  logic       out_fire;

  //////////////////////////////
  // sticky handshake flags
  //////////////////////////////

  // bit order from high to low follows the output, then branch b, a, input.
  assign seen_now = {out_ready_i, out_valid_i,
                     b_ready_i,   b_valid_i,
                     a_ready_i,   a_valid_i,
                     in_ready_i,  in_valid_i};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) seen_q <= '0;
    else        seen_q <= seen_q | seen_now;  // a flag never drops once set.
  end

  //////////////////////////////
  // group counter and capture
  //////////////////////////////

  assign out_fire = out_valid_i && out_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      groups_q <= '0;
      score_q  <= '0;
    end else if (out_fire) begin
      groups_q <= groups_q + 1'b1;
      // groups_q still holds the index of the group on the output now.
      if (groups_q == dbg_group_i) score_q <= out_score_i;
    end
  end

  assign dbg_flags_o  = seen_q;
  assign dbg_groups_o = groups_q;
  assign dbg_score_o  = score_q;

endmodule

`default_nettype wire

//--- rtl/row_aggregator.sv
`default_nettype none

`include "gat_defs.svh"

module row_aggregator
  import gat_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire logic      spmm_valid_i,
  input  wire spmm_res_t spmm_res_i,
  output logic           spmm_ready_o,
  input  wire logic      score_valid_i,
  input  wire acc_t      score_i,
  output logic           score_ready_o,
  output logic           out_valid_o,
  output out_rec_t       out_rec_o,
  input  wire logic      out_ready_i
);

  // largest value an output lane can hold, widened to the accumulator.
  localparam acc_t LANE_MAX = acc_t'({`GAT_OUT_W{1'b1}});

  logic     out_valid_q;
  out_rec_t out_rec_q;
  out_vec_t lane_d;
  logic     join_fire;

  // both results must be present and the output register free.
  assign join_fire     = spmm_valid_i && score_valid_i && (!out_valid_q || out_ready_i);
  assign spmm_ready_o  = join_fire;
  assign score_ready_o = join_fire;
  assign out_valid_o   = out_valid_q;
  assign out_rec_o     = out_rec_q;

  //////////////////////////////
  // relu and clip
  //////////////////////////////

  always_comb begin
    acc_t v;
    for (int i = 0; i < `GAT_LANES; i++) begin
      v = $signed(spmm_res_i.acc[i]);
      if (v < 0)             lane_d[i] = '0;
      else if (v > LANE_MAX) lane_d[i] = '1;
      else                   lane_d[i] = v[`GAT_OUT_W-1:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid_q <= 1'b0;
    end else if (join_fire) begin
      out_valid_q <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (join_fire) begin
      out_rec_q.lane     <= lane_d;
      out_rec_q.score    <= score_i;              // score passes through signed.
      out_rec_q.edge_cnt <= spmm_res_i.edge_cnt;
    end
  end

  // a waiting score stays put until the join takes it.
  a_score_hold: assert property (@(posedge clk) disable iff (!rst_n)
    score_valid_i && !score_ready_o |=> score_valid_i && $stable(score_i));

endmodule

`default_nettype wire

//--- rtl/dmvm_unit.sv
`default_nettype none

`include "gat_defs.svh"

module dmvm_unit
  import gat_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire logic      edge_valid_i,
  input  wire edge_rec_t edge_rec_i,
  output logic           edge_ready_o,
  input  wire feat_vec_t wgt_i,
  output logic           score_valid_o,
  output acc_t           score_o,
  input  wire logic      score_ready_i
);

  localparam int PROD_W = 2 * `GAT_FEAT_W;

  acc_t dot_d;
  acc_t dot_q;
  logic p_valid_q;
  logic p_last_q;
  logic grp_open_q;  // max_q holds at least one edge of this group.
  acc_t max_q;
  acc_t max_d;
  logic score_valid_q;
  acc_t score_q;
  logic edge_fire;

  assign edge_ready_o  = !score_valid_q && !(p_valid_q && p_last_q);
  assign edge_fire     = edge_valid_i && edge_ready_o;
  assign score_valid_o = score_valid_q;
  assign score_o       = score_q;

  //////////////////////////////
  // dot product stage
  //////////////////////////////

  always_comb begin
    logic signed [PROD_W-1:0] prod;
    dot_d = '0;
    for (int i = 0; i < `GAT_LANES; i++) begin
      prod  = $signed(edge_rec_i.feat[i]) * $signed(wgt_i[i]);
      dot_d = dot_d + prod;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      p_valid_q <= 1'b0;
      p_last_q  <= 1'b0;
    end else begin
      p_valid_q <= edge_fire;
      if (edge_fire) p_last_q <= edge_rec_i.last;
    end
  end

  always_ff @(posedge clk) begin
    if (edge_fire) dot_q <= dot_d;
  end

  //////////////////////////////
  // running maximum
  //////////////////////////////

  // the first edge of a group loads the maximum directly.
  assign max_d = (!grp_open_q || dot_q > max_q) ? dot_q : max_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      grp_open_q    <= 1'b0;
      max_q         <= '0;
      score_valid_q <= 1'b0;
    end else begin
      if (p_valid_q) begin
        grp_open_q <= !p_last_q;
        max_q      <= max_d;
      end
      if (p_valid_q && p_last_q) score_valid_q <= 1'b1;
      else if (score_ready_i)    score_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (p_valid_q && p_last_q) score_q <= max_d;
  end

endmodule

`default_nettype wire

//--- rtl/spmm_unit.sv
`default_nettype none

`include "gat_defs.svh"

module spmm_unit
  import gat_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire logic      edge_valid_i,
  input  wire edge_rec_t edge_rec_i,
  output logic           edge_ready_o,
  output logic           res_valid_o,
  output spmm_res_t      res_o,
  input  wire logic      res_ready_i
);

  localparam int PROD_W = 2 * `GAT_FEAT_W;

  logic                     p_valid_q;
  logic                     p_last_q;
  logic signed [PROD_W-1:0] p_prod_q [`GAT_LANES];
  acc_t                     acc_q    [`GAT_LANES];
  acc_t                     acc_sum  [`GAT_LANES];
  cnt_t                     cnt_q;
  logic                     res_valid_q;
  spmm_res_t                res_q;
  logic                     edge_fire;

  // a group end in the product stage blocks input until the result is loaded.
  assign edge_ready_o = !res_valid_q && !(p_valid_q && p_last_q);
  assign edge_fire    = edge_valid_i && edge_ready_o;
  assign res_valid_o  = res_valid_q;
  assign res_o        = res_q;

  //////////////////////////////
  // product stage
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      p_valid_q <= 1'b0;
      p_last_q  <= 1'b0;
    end else begin
      p_valid_q <= edge_fire;
      if (edge_fire) p_last_q <= edge_rec_i.last;
    end
  end

  always_ff @(posedge clk) begin
    if (edge_fire) begin
      for (int i = 0; i < `GAT_LANES; i++) begin
        p_prod_q[i] <= $signed(edge_rec_i.coef) * $signed(edge_rec_i.feat[i]);
      end
    end
  end

  //////////////////////////////
  // accumulate stage
  //////////////////////////////

  always_comb begin
    for (int i = 0; i < `GAT_LANES; i++) begin
      acc_sum[i] = acc_q[i] + p_prod_q[i];  // product is sign extended.
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `GAT_LANES; i++) acc_q[i] <= '0;
      cnt_q       <= '0;
      res_valid_q <= 1'b0;
    end else begin
      if (p_valid_q) begin
        for (int i = 0; i < `GAT_LANES; i++) begin
          acc_q[i] <= p_last_q ? acc_t'(0) : acc_sum[i];
        end
        cnt_q <= p_last_q ? cnt_t'(0) : cnt_q + 1'b1;
      end
      if (p_valid_q && p_last_q) res_valid_q <= 1'b1;
      else if (res_ready_i)      res_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (p_valid_q && p_last_q) begin
      for (int i = 0; i < `GAT_LANES; i++) res_q.acc[i] <= acc_sum[i];
      res_q.edge_cnt <= cnt_q + 1'b1;  // the last edge counts too.
    end
  end

  a_res_stable: assert property (@(posedge clk) disable iff (!rst_n)
    res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_o));

endmodule

`default_nettype wire

//--- rtl/edge_dispatch.sv
`default_nettype none

module edge_dispatch
  import gat_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire logic      in_valid_i,
  input  wire edge_rec_t in_rec_i,
  output logic           in_ready_o,
  output logic           a_valid_o,
  output edge_rec_t      a_rec_o,
  input  wire logic      a_ready_i,
  output logic           b_valid_o,
  output edge_rec_t      b_rec_o,
  input  wire logic      b_ready_i
);

  edge_rec_t rec_q;
  logic      a_pend_q;  // branch a has not taken rec_q yet.
  logic      b_pend_q;
  logic      in_fire;

  // the buffer frees up when every branch still holding it takes it now.
  assign in_ready_o = (!a_pend_q || a_ready_i) && (!b_pend_q || b_ready_i);
  assign in_fire    = in_valid_i && in_ready_o;

  assign a_valid_o = a_pend_q;
  assign b_valid_o = b_pend_q;
  assign a_rec_o   = rec_q;
  assign b_rec_o   = rec_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_pend_q <= 1'b0;
      b_pend_q <= 1'b0;
    end else if (in_fire) begin
      a_pend_q <= 1'b1;
      b_pend_q <= 1'b1;
    end else begin
      if (a_ready_i) a_pend_q <= 1'b0;
      if (b_ready_i) b_pend_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) rec_q <= in_rec_i;
  end

  // the upstream source must hold its record until it is accepted.
  a_in_stable: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_rec_i));

endmodule

`default_nettype wire

//--- rtl/gat_pkg.sv
`default_nettype none

`include "gat_defs.svh"

package gat_pkg;

  //////////////////////////////
  // scalar types
  //////////////////////////////

  typedef logic signed [`GAT_FEAT_W-1:0] feat_t;
  typedef logic signed [`GAT_ACC_W-1:0]  acc_t;
  typedef logic        [`GAT_OUT_W-1:0]  out_lane_t;
  typedef logic        [`GAT_CNT_W-1:0]  cnt_t;
  typedef logic        [7:0]             dbg_flags_t;  // sticky handshake flags.

  //////////////////////////////
  // vectors and records
  //////////////////////////////

  typedef feat_t     [`GAT_LANES-1:0] feat_vec_t;
  typedef acc_t      [`GAT_LANES-1:0] acc_vec_t;
  typedef out_lane_t [`GAT_LANES-1:0] out_vec_t;

  typedef struct packed {
    feat_t     coef;
    feat_vec_t feat;
    logic      last;  // closes the destination row.
  } edge_rec_t;

  typedef struct packed {
    acc_vec_t acc;
    cnt_t     edge_cnt;
  } spmm_res_t;

  typedef struct packed {
    out_vec_t lane;
    acc_t     score;
    cnt_t     edge_cnt;
  } out_rec_t;

endpackage

`default_nettype wire

//--- include/gat_defs.svh
`ifndef GAT_DEFS_SVH
`define GAT_DEFS_SVH

// number of feature lanes in one edge record.
`define GAT_LANES 4

// width of a feature and of an edge coefficient.
`define GAT_FEAT_W 8

// accumulators and scores need headroom for long groups.
`define GAT_ACC_W 24

// width of one clipped output lane.
`define GAT_OUT_W 16

// edge and group counters.
`define GAT_CNT_W 16

`endif
